//--- vlog.f
+incdir+verif
verilog/rv_pkg.sv
verilog/rv_fwd_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_forward.sv
verilog/rv_execute.sv
verilog/rv_stage_reg.sv
verilog/rv_core.sv
verif/tb_rv_core.sv

//--- verif/rv_ref_model.svh
// encoders take register numbers and the immediate in instruction order
function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                       input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
endfunction

function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rv_pkg::op_lui};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
endfunction

function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// initial data memory contents
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
endfunction

function automatic void emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
endfunction

function automatic void build_program(input int t);
    logic [31:0] r;
    logic [31:0] v;
    int          kind;
    logic [2:0]  f3_tab [7];
    f3_tab = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    prog_len = 0;
    for (int i = 0; i < 64; i++) begin
        prog[i] = i_type(rv_pkg::op_imm, 3'd0, 5'd0, 5'd0, 12'd0);
    end
    case (t)
        1: begin
            emit(u_type(5'd1, 20'h12345));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd2, 5'd1, 12'h678));
            emit(r_type(3'd0, 7'h00, 5'd3, 5'd2, 5'd1));
            emit(r_type(3'd0, 7'h20, 5'd4, 5'd3, 5'd2));
            emit(r_type(3'd4, 7'h00, 5'd5, 5'd4, 5'd3));
            // x3 now sits in writeback
            emit(r_type(3'd6, 7'h00, 5'd6, 5'd5, 5'd3));
            emit(r_type(3'd7, 7'h00, 5'd7, 5'd6, 5'd1));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd8, 5'd0, 12'hffb));
            emit(r_type(3'd2, 7'h00, 5'd9, 5'd8, 5'd7));
            emit(r_type(3'd3, 7'h00, 5'd10, 5'd8, 5'd7));
        end
        2: begin
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd1, 5'd0, 12'h040));
            emit(u_type(5'd2, 20'hcafe0));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd2, 5'd2, 12'h123));
            emit(s_type(5'd2, 5'd1, 12'h008));
            emit(i_type(rv_pkg::op_load, 3'd2, 5'd3, 5'd1, 12'h008));
            emit(r_type(3'd0, 7'h00, 5'd4, 5'd3, 5'd2));
            emit(i_type(rv_pkg::op_load, 3'd2, 5'd5, 5'd1, 12'h010));
            // store data straight from a load
            emit(s_type(5'd5, 5'd1, 12'h00c));
            emit(i_type(rv_pkg::op_load, 3'd2, 5'd6, 5'd1, 12'h00c));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd7, 5'd0, 12'h001));
            emit(r_type(3'd0, 7'h00, 5'd8, 5'd6, 5'd7));
        end
        3: begin
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd1, 5'd0, 12'd5));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd2, 5'd0, 12'd5));
            emit(b_type(3'd0, 5'd1, 5'd2, 13'd12));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd3, 5'd0, 12'd1));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd4, 5'd0, 12'd2));
            emit(b_type(3'd1, 5'd1, 5'd2, 13'd8));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd5, 5'd0, 12'd3));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd2, 5'd2, 12'd1));
            emit(b_type(3'd1, 5'd1, 5'd2, 13'd12));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd6, 5'd0, 12'd4));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd7, 5'd0, 12'd5));
            emit(b_type(3'd0, 5'd1, 5'd2, 13'd8));
            emit(j_type(5'd8, 21'd12));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd9, 5'd0, 12'd6));
            emit(i_type(rv_pkg::op_imm, 3'd0, 5'd10, 5'd0, 12'd7));
            emit(r_type(3'd0, 7'h00, 5'd11, 5'd8, 5'd5));
        end
        4: begin
            rng_state = 78871;
            for (int i = 0; i < 40; i++) begin
                r = xorshift();
                v = xorshift();
                kind = r % 11;
                case (kind)
                    0: emit(u_type({2'b0, r[10:8]}, v[19:0]));
                    1: emit(i_type(rv_pkg::op_imm, 3'd0, {2'b0, r[10:8]}, {2'b0, r[13:11]},
                                   v[11:0]));
                    9: emit(i_type(rv_pkg::op_load, 3'd2, {2'b0, r[10:8]}, 5'd0,
                                   {4'b0, v[7:2], 2'b0}));
                    10: emit(s_type({2'b0, r[16:14]}, 5'd0, {4'b0, v[7:2], 2'b0}));
                    default: emit(r_type(f3_tab[kind-2], (kind == 3) ? 7'h20 : 7'h00,
                                         {2'b0, r[10:8]}, {2'b0, r[13:11]},
                                         {2'b0, r[16:14]}));
                endcase
            end
        end
        default: ;
    endcase
    // self-loop, its link write marks the end of the program
    emit(j_type(5'd31, 21'd0));
endfunction

// architectural model, returns the number of executed instructions
function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] dm [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic        wr;
    int          steps;
    exp_regs.delete();
    exp_stores.delete();
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        dm[i] = fill_word(i * 4);
    end
    pc = rv_pkg::start_addr;
    steps = 0;
    while (steps < 1000) begin
        ins = prog[pc[7:2]];
        a = x[ins[19:15]];
        b = x[ins[24:20]];
        res = '0;
        wr = 1'b1;
        next_pc = pc + 4;
        steps++;
        case (ins[6:0])
            rv_pkg::op_lui: res = {ins[31:12], 12'b0};
            rv_pkg::op_imm: res = a + {{20{ins[31]}}, ins[31:20]};
            rv_pkg::op_reg: begin
                case (ins[14:12])
                    3'd0: res = ins[30] ? a - b : a + b;
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            rv_pkg::op_load: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                res = dm[addr[9:2]];
            end
            rv_pkg::op_store: begin
                wr = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dm[addr[9:2]] = b;
                exp_stores.push_back(store_t'{addr, b});
            end
            rv_pkg::op_branch: begin
                wr = 1'b0;
                // funct3 bit 0 set means bne
                if ((a == b) != ins[12]) begin
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rv_pkg::op_jal: begin
                res = pc + 4;
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
            exp_regs.push_back(reg_write_t'{ins[11:7], res});
        end
        if (next_pc == pc) begin
            break;
        end
        pc = next_pc;
    end
    return steps;
endfunction

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_re;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] prog [64];
    int          prog_len;
    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] rng_state;
    reg_write_t  exp_regs [$];
    store_t      exp_stores [$];

    logic checking;
    int   errors;
    int   passed;
    int   failed;
    int   cycle_count;
    int   cycle_limit;

    `include "rv_ref_model.svh"

    rv_core UUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_re(dmem_re), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    always #10 clk = ~clk;

    // both memories answer one cycle after the request
    always @(posedge clk) begin
        imem_rdata <= imem[imem_addr[7:2]];
        if (dmem_re) begin
            dmem_rdata <= dmem[dmem_addr[9:2]];
        end
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // retire and store streams against the model
    always @(negedge clk) begin
        reg_write_t exp_w;
        store_t     exp_s;
        if (checking && retire_valid) begin
            assert (exp_regs.size() > 0) else begin
                $display("unexpected register write to x%0d", retire_rd);
                errors++;
            end
            if (exp_regs.size() > 0) begin
                exp_w = exp_regs.pop_front();
                assert (retire_rd == exp_w.rd) else begin
                    $display("** Error retire_rd expected %h got %h", exp_w.rd, retire_rd);
                    errors++;
                end
                assert (retire_data == exp_w.data) else begin
                    $display("** Error retire_data expected %h got %h", exp_w.data, retire_data);
                    errors++;
                end
            end
        end
        if (checking && dmem_we) begin
            assert (exp_stores.size() > 0) else begin
                $display("unexpected store to address %h", dmem_addr);
                errors++;
            end
            if (exp_stores.size() > 0) begin
                exp_s = exp_stores.pop_front();
                assert (dmem_addr == exp_s.addr) else begin
                    $display("** Error dmem_addr expected %h got %h", exp_s.addr, dmem_addr);
                    errors++;
                end
                assert (dmem_wdata == exp_s.data) else begin
                    $display("** Error dmem_wdata expected %h got %h", exp_s.data, dmem_wdata);
                    errors++;
                end
            end
        end
    end

    task automatic check_idle(input string phase);
        assert (!retire_valid && !dmem_we && !dmem_re) else begin
            $display("core not idle %s: retire_valid %b dmem_we %b dmem_re %b",
                     phase, retire_valid, dmem_we, dmem_re);
            errors++;
        end
        assert (imem_addr == rv_pkg::start_addr) else begin
            $display("** Error imem_addr expected %h got %h", rv_pkg::start_addr, imem_addr);
            errors++;
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = prog[i];
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i * 4);
        end
    endtask

    task automatic run_test(input int t, input string name);
        build_program(t);
        void'(run_model());
        errors = 0;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i == 1) begin
                load_memories();
            end
            if (i > 0) begin
                check_idle("during reset");
            end
            @(posedge clk);
        end
        rst_n <= 1'b1;
        checking = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        while (exp_regs.size() > 0 || exp_stores.size() > 0) begin
            @(posedge clk);
        end
        checking = 1'b0;
        if (errors == 0) begin
            passed++;
            $display("test %0d %s: ok", t, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", t, name, errors);
        end
    endtask

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a program never reached its end", cycle_count);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int total;
        clk = 1'b0;
        rst_n = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        checking = 1'b0;
        passed = 0;
        failed = 0;
        cycle_count = 0;
        cycle_limit = 0;
        total = 0;
        for (int t = 0; t < 5; t++) begin
            build_program(t);
            total += run_model();
        end
        cycle_limit = 4 * total + 200;
        run_test(0, "reset");
        run_test(1, "alu chain");
        run_test(2, "load use and stores");
        run_test(3, "control flow");
        run_test(4, "random block");
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_pkg::xlen-1:0]       imem_rdata,
    output logic                          dmem_re,
    output logic                          dmem_we,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
    output logic                          retire_valid,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data
);

    rv_pkg::fd_payload_t fd_in;
    rv_pkg::fd_payload_t fd_out;
    rv_pkg::de_payload_t de_in;
    rv_pkg::de_payload_t de_out;
    rv_pkg::em_payload_t em_in;
    rv_pkg::em_payload_t em_out;
    rv_pkg::mw_payload_t mw_in;
    rv_pkg::mw_payload_t mw_out;

    logic fd_valid;
    logic de_valid;
    logic em_valid;
    logic mw_valid;

    logic                          load_stall;
    logic                          redirect;
    logic                          front_hold;
    logic                          de_flush;
    logic [rv_pkg::xlen-1:0]       target;
    logic [rv_pkg::xlen-1:0]       fetch_pc;
    rv_pkg::rv_op_e                dec_op;
    logic [rv_pkg::reg_addr_w-1:0] dec_rs1;
    logic [rv_pkg::reg_addr_w-1:0] dec_rs2;
    logic [rv_pkg::reg_addr_w-1:0] dec_rd;
    logic [rv_pkg::xlen-1:0]       dec_imm;
    logic                          dec_writes;
    logic [rv_pkg::xlen-1:0]       rs1_reg;
    logic [rv_pkg::xlen-1:0]       rs2_reg;
    logic [rv_pkg::xlen-1:0]       op_a;
    logic [rv_pkg::xlen-1:0]       op_b;
    logic [rv_pkg::xlen-1:0]       ex_result;
    logic                          ex_is_load;
    logic [rv_pkg::xlen-1:0]       ma_data;

    rv_fwd_if fwd (.clk(clk));

    // redirect wins over a load-use stall
    assign front_hold = load_stall && !redirect;
    assign de_flush   = load_stall || redirect;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .hold(front_hold), .redirect(redirect),
        .target(target), .pc(fetch_pc), .imem_addr(imem_addr)
    );

    assign fd_in = '{pc: imem_addr};

    rv_stage_reg #(.payload_t(rv_pkg::fd_payload_t)) u_fd (
        .clk(clk), .rst_n(rst_n), .hold(front_hold), .flush(redirect),
        .in_valid(1'b1), .in_data(fd_in), .out_valid(fd_valid), .out_data(fd_out)
    );

    rv_decode u_decode (
        .instr(imem_rdata), .op(dec_op), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .imm(dec_imm), .writes_reg(dec_writes)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_val(rs1_reg), .rs2_val(rs2_reg),
        .we(retire_valid), .wd_rd(retire_rd), .wd_data(retire_data)
    );

    rv_forward u_forward (
        .fwd(fwd.sink), .rs1(dec_rs1), .rs2(dec_rs2), .rs1_reg(rs1_reg), .rs2_reg(rs2_reg),
        .de_valid(fd_valid), .rs1_val(op_a), .rs2_val(op_b), .load_stall(load_stall)
    );

    assign de_in = '{pc: fd_out.pc, op: dec_op, rd: dec_rd, rs1_val: op_a, rs2_val: op_b,
                     imm: dec_imm, writes_reg: dec_writes};

    rv_stage_reg #(.payload_t(rv_pkg::de_payload_t)) u_de (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(de_flush),
        .in_valid(fd_valid), .in_data(de_in), .out_valid(de_valid), .out_data(de_out)
    );

    rv_execute u_execute (
        .valid(de_valid), .payload(de_out), .result(ex_result), .redirect(redirect),
        .target(target), .dmem_re(dmem_re), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    assign ex_is_load     = de_out.op == rv_pkg::op_lw;
    assign fwd.ex_valid   = de_valid && de_out.writes_reg;
    assign fwd.ex_rd      = de_out.rd;
    assign fwd.ex_is_load = ex_is_load;
    assign fwd.ex_result  = ex_result;

    assign em_in = '{op: de_out.op, rd: de_out.rd, result: ex_result,
                     writes_reg: de_out.writes_reg, is_load: ex_is_load};

    rv_stage_reg #(.payload_t(rv_pkg::em_payload_t)) u_em (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(1'b0),
        .in_valid(de_valid), .in_data(em_in), .out_valid(em_valid), .out_data(em_out)
    );

    // memory stage
    assign ma_data      = em_out.is_load ? dmem_rdata : em_out.result;
    assign fwd.ma_valid = em_valid && em_out.writes_reg;
    assign fwd.ma_rd    = em_out.rd;
    assign fwd.ma_data  = ma_data;

    assign mw_in = '{rd: em_out.rd, data: ma_data, writes_reg: em_out.writes_reg};

    rv_stage_reg #(.payload_t(rv_pkg::mw_payload_t)) u_mw (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(1'b0),
        .in_valid(em_valid), .in_data(mw_in), .out_valid(mw_valid), .out_data(mw_out)
    );

    assign retire_valid = mw_valid && mw_out.writes_reg && mw_out.rd != '0;
    assign retire_rd    = mw_out.rd;
    assign retire_data  = mw_out.data;

    // instruction word on imem_rdata belongs to the pc held in fd
    fd_pc_match: assert property (@(posedge clk) disable iff (!rst_n)
        fd_valid |-> fd_out.pc == fetch_pc);

    // read data lands while its load sits in the memory stage
    load_data_align: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_re |=> em_valid && em_out.op == rv_pkg::op_lw);

endmodule

//--- verilog/rv_stage_reg.sv
`timescale 1ns/1ps

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    hold_xor_flush: assert property (@(posedge clk) disable iff (!rst_n) !(hold && flush));

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                    valid,
    input  rv_pkg::de_payload_t     payload,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] target,
    output logic                    dmem_re,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata
);

    logic [rv_pkg::xlen-1:0] a;
    logic [rv_pkg::xlen-1:0] b;
    logic                    taken;

    assign a = payload.rs1_val;
    assign b = payload.rs2_val;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (payload.op)
            rv_pkg::op_upper: result = payload.imm;
            rv_pkg::op_addi,
            rv_pkg::op_lw,
            rv_pkg::op_sw:    result = a + payload.imm;
            rv_pkg::op_add:   result = a + b;
            rv_pkg::op_sub:   result = a - b;
            rv_pkg::op_and:   result = a & b;
            rv_pkg::op_or:    result = a | b;
            rv_pkg::op_xor:   result = a ^ b;
            rv_pkg::op_slt:   result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::op_sltu:  result = {31'b0, a < b};
            rv_pkg::op_beq:   taken = (a == b);
            rv_pkg::op_bne:   taken = (a != b);
            rv_pkg::op_jump: begin
                // link value
                result = payload.pc + 4;
                taken  = 1'b1;
            end
            default: result = '0;
        endcase
    end

    assign redirect = valid && taken;
    assign target   = payload.pc + payload.imm;

    assign dmem_re    = valid && payload.op == rv_pkg::op_lw;
    assign dmem_we    = valid && payload.op == rv_pkg::op_sw;
    assign dmem_addr  = result;
    assign dmem_wdata = b;

endmodule

//--- verilog/rv_forward.sv
`timescale 1ns/1ps

module rv_forward (
    rv_fwd_if.sink                        fwd,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::xlen-1:0]       rs1_reg,
    input  logic [rv_pkg::xlen-1:0]       rs2_reg,
    input  logic                          de_valid,
    output logic [rv_pkg::xlen-1:0]       rs1_val,
    output logic [rv_pkg::xlen-1:0]       rs2_val,
    output logic                          load_stall
);

    logic rs1_ex;
    logic rs2_ex;
    logic rs1_ma;
    logic rs2_ma;

    // x0 never matches a producer
    assign rs1_ex = fwd.ex_valid && rs1 != '0 && fwd.ex_rd == rs1;
    assign rs2_ex = fwd.ex_valid && rs2 != '0 && fwd.ex_rd == rs2;
    assign rs1_ma = fwd.ma_valid && rs1 != '0 && fwd.ma_rd == rs1;
    assign rs2_ma = fwd.ma_valid && rs2 != '0 && fwd.ma_rd == rs2;

    // youngest producer first
    assign rs1_val = (rs1_ex && !fwd.ex_is_load) ? fwd.ex_result :
                     rs1_ma ? fwd.ma_data : rs1_reg;
    assign rs2_val = (rs2_ex && !fwd.ex_is_load) ? fwd.ex_result :
                     rs2_ma ? fwd.ma_data : rs2_reg;

    // load data only exists one stage later
    assign load_stall = de_valid && fwd.ex_is_load && (rs1_ex || rs2_ex);

    // the bubble must clear execute, so the retry reads the load from the memory stage
    one_bubble: assert property (@(posedge fwd.clk) load_stall |=> !load_stall);

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_val,
    output logic [rv_pkg::xlen-1:0]       rs2_val,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] wd_rd,
    input  logic [rv_pkg::xlen-1:0]       wd_data
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_rd != '0) begin
            regs[wd_rd] <= wd_data;
        end
    end

    // writeback in the same cycle passes straight to decode
    assign rs1_val = (rs1 == '0) ? '0 : (we && wd_rd == rs1) ? wd_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (we && wd_rd == rs2) ? wd_data : regs[rs2];

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::xlen-1:0]       instr,
    output rv_pkg::rv_op_e                op,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    output logic [rv_pkg::xlen-1:0]       imm,
    output logic                          writes_reg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        op  = rv_pkg::op_nop;
        imm = '0;
        case (opcode)
            rv_pkg::op_lui: begin
                op  = rv_pkg::op_upper;
                imm = {instr[31:12], 12'b0};
            end
            rv_pkg::op_imm: begin
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b000) begin
                    op = rv_pkg::op_addi;
                end
            end
            rv_pkg::op_reg: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = rv_pkg::op_add;
                    10'b0100000_000: op = rv_pkg::op_sub;
                    10'b0000000_010: op = rv_pkg::op_slt;
                    10'b0000000_011: op = rv_pkg::op_sltu;
                    10'b0000000_100: op = rv_pkg::op_xor;
                    10'b0000000_110: op = rv_pkg::op_or;
                    10'b0000000_111: op = rv_pkg::op_and;
                    default:         op = rv_pkg::op_nop;
                endcase
            end
            rv_pkg::op_load: begin
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == 3'b010) begin
                    op = rv_pkg::op_lw;
                end
            end
            rv_pkg::op_store: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) begin
                    op = rv_pkg::op_sw;
                end
            end
            rv_pkg::op_branch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    op = rv_pkg::op_beq;
                end else if (funct3 == 3'b001) begin
                    op = rv_pkg::op_bne;
                end
            end
            rv_pkg::op_jal: begin
                op  = rv_pkg::op_jump;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                op = rv_pkg::op_nop;
            end
        endcase
    end

    assign writes_reg = !(op inside {rv_pkg::op_nop, rv_pkg::op_sw, rv_pkg::op_beq,
                                     rv_pkg::op_bne});

endmodule

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hold,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] target,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] imem_addr
);

    // set after reset and after a redirect, pc is requested again
    logic replay;

    always_comb begin
        if (redirect) begin
            imem_addr = target;
        end else if (hold || replay) begin
            imem_addr = pc;
        end else begin
            imem_addr = pc + 4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= rv_pkg::start_addr;
            replay <= 1'b1;
        end else begin
            pc     <= imem_addr;
            replay <= redirect || (replay && hold);
        end
    end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00);

endmodule

//--- verilog/rv_fwd_if.sv
`timescale 1ns/1ps

interface rv_fwd_if (
    input logic clk
);
    // producer in execute
    logic                          ex_valid;
    logic [rv_pkg::reg_addr_w-1:0] ex_rd;
    logic                          ex_is_load;
    logic [rv_pkg::xlen-1:0]       ex_result;

    // producer in memory stage, load data already merged
    logic                          ma_valid;
    logic [rv_pkg::reg_addr_w-1:0] ma_rd;
    logic [rv_pkg::xlen-1:0]       ma_data;

    modport source (
        output ex_valid, ex_rd, ex_is_load, ex_result,
        output ma_valid, ma_rd, ma_data
    );

    modport sink (
        input clk,
        input ex_valid, ex_rd, ex_is_load, ex_result,
        input ma_valid, ma_rd, ma_data
    );

endinterface

//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] start_addr = 32'h0000_0000;

    // major opcode field, instr[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        op_nop, op_upper, op_addi, op_add,
        op_sub, op_and, op_or, op_xor,
        op_slt, op_sltu, op_lw, op_sw,
        op_beq, op_bne, op_jump
    } rv_op_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
    } fd_payload_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        rv_op_e                op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic                  writes_reg;
    } de_payload_t;

    typedef struct packed {
        rv_op_e                op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  writes_reg;
        logic                  is_load;
    } em_payload_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  writes_reg;
    } mw_payload_t;

endpackage
